//--- nand_cpu_defs.svh
`ifndef NAND_CPU_DEFS_SVH
`define NAND_CPU_DEFS_SVH

// instruction address width.
`define PC_SIZE 16

// log2 of the number of target buffer entries.
// 4 gives 16 entries; the tag takes the remaining pc bits.
`define BTB_INDEX_SIZE 4

// global history length.
// this is also the width of the counter table index, so 6 gives 64 counters.
`define GHR_SIZE 6

// width of the tag kept per buffer entry.
`define BTB_TAG_SIZE (`PC_SIZE - `BTB_INDEX_SIZE)

`endif

//--- cpu_pkg.sv
`include "nand_cpu_defs.svh"

// types shared across the cpu, not just the fetch-stage predictor.
package cpu_pkg;

    // instruction address.
    typedef logic [`PC_SIZE-1:0] pc_t;

endpackage

//--- bp_pkg.sv
`include "nand_cpu_defs.svh"

package bp_pkg;
    import cpu_pkg::*;

    // 2-bit saturating counter, upper half means taken.
    typedef logic [1:0] counter_t;

    localparam counter_t COUNTER_RESET = 2'd1; // weakly not taken.
    localparam counter_t COUNTER_MAX   = 2'd3;

    typedef logic [`GHR_SIZE-1:0]       ghr_t;
    typedef logic [`BTB_INDEX_SIZE-1:0] btb_index_t;
    typedef logic [`BTB_TAG_SIZE-1:0]   btb_tag_t;

    typedef struct packed {
        logic     valid;
        btb_tag_t tag;
        pc_t      target;
    } btb_entry_t;

    localparam btb_entry_t BTB_EMPTY = '0;

    // low pc bits select the buffer entry.
    function automatic btb_index_t btb_index(input pc_t addr);
        return addr[`BTB_INDEX_SIZE-1:0];
    endfunction

    function automatic btb_tag_t btb_tag(input pc_t addr);
        return addr[`PC_SIZE-1:`BTB_INDEX_SIZE];
    endfunction

    function automatic logic counter_taken(input counter_t count);
        return count[1];
    endfunction

    // step toward the outcome, holding at either end.
    function automatic counter_t counter_update(input counter_t count, input logic up);
        counter_t next;
        next = count;
        if (up && count != COUNTER_MAX) begin
            next = count + 2'd1;
        end else if (!up && count != '0) begin
            next = count - 2'd1;
        end
        return next;
    endfunction

endpackage

//--- pred_table.sv
// indexed register table used for both the target buffer and the counters.
// two combinational read ports, one synchronous write port.
module pred_table #(
    parameter type    entry_t     = logic [1:0],
    parameter int     DEPTH_LOG2  = 4,
    parameter entry_t RESET_VALUE = '0
) (
    input  logic                  clk,
    input  logic                  n_rst,

    // lookup read.
    input  logic [DEPTH_LOG2-1:0] rd_index,
    output entry_t                rd_data,

    // update write.
    input  logic                  wr_en,
    input  logic [DEPTH_LOG2-1:0] wr_index,
    input  entry_t                wr_data,

    // second read for the read-modify-write on the update side.
    input  logic [DEPTH_LOG2-1:0] rd2_index,
    output entry_t                rd2_data
);

    localparam int DEPTH = 2 ** DEPTH_LOG2;

    entry_t entries [DEPTH];

    // reads see the old contents during the write cycle.
    assign rd_data  = entries[rd_index];
    assign rd2_data = entries[rd2_index];

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                entries[i] <= RESET_VALUE;
            end
        end else if (wr_en) begin
            entries[wr_index] <= wr_data;
        end
    end

endmodule

//--- branch_target_buffer.sv
// direct-mapped, tagged target buffer.
// filled by taken resolves, cleared when decode says the pc is not a branch.
module branch_target_buffer
    import cpu_pkg::*;
    import bp_pkg::*;
(
    input  logic clk,
    input  logic n_rst,

    // fetch lookup.
    input  pc_t  pc,

    // decode report.
    input  logic bv_valid,
    input  logic bv_branch,
    input  pc_t  bv_pc,

    // resolve report.
    input  logic bo_valid,
    input  logic bo_taken,
    input  pc_t  bo_pc,
    input  pc_t  bo_target,

    output logic hit,
    output pc_t  target
);

    btb_index_t lookup_index;
    btb_index_t bv_index;
    btb_index_t bo_index;
    btb_index_t wr_index;

    btb_entry_t lookup_entry;
    btb_entry_t bv_entry;
    btb_entry_t wr_entry;

    logic fill;
    logic clear;
    logic wr_en;

    assign lookup_index = btb_index(pc);
    assign bv_index     = btb_index(bv_pc);
    assign bo_index     = btb_index(bo_pc);

    assign hit    = lookup_entry.valid && (lookup_entry.tag == btb_tag(pc));
    assign target = lookup_entry.target;

    assign fill = bo_valid && bo_taken;

    // only drop the entry if it really belongs to this pc.
    assign clear = bv_valid && !bv_branch && bv_entry.valid
                   && (bv_entry.tag == btb_tag(bv_pc));

    assign wr_en = fill || clear;

    // a fill wins over a clear in the same cycle.
    always_comb begin
        if (fill) begin
            wr_index = bo_index;
            wr_entry = '{valid: 1'b1, tag: btb_tag(bo_pc), target: bo_target};
        end else begin
            wr_index = bv_index;
            wr_entry = BTB_EMPTY;
        end
    end

    pred_table #(
        .entry_t     (btb_entry_t),
        .DEPTH_LOG2  ($bits(btb_index_t)),
        .RESET_VALUE (BTB_EMPTY)
    ) u_entries (
        .clk       (clk),
        .n_rst     (n_rst),
        .rd_index  (lookup_index),
        .rd_data   (lookup_entry),
        .wr_en     (wr_en),
        .wr_index  (wr_index),
        .wr_data   (wr_entry),
        .rd2_index (bv_index),  // tag check for the decode clear.
        .rd2_data  (bv_entry)
    );

endmodule

//--- branch_predictor_gshare.sv
`include "nand_cpu_defs.svh"

// gshare direction predictor.
// history xor pc picks a 2-bit counter for both lookup and training.
module branch_predictor_gshare
    import cpu_pkg::*;
    import bp_pkg::*;
(
    input  logic clk,
    input  logic n_rst,

    input  pc_t  pc,

    // resolve report.
    input  logic bo_valid,
    input  logic bo_taken,
    input  pc_t  bo_pc,

    output logic taken
);

    ghr_t history;

    ghr_t lookup_index;
    ghr_t fb_index;

    counter_t lookup_count;
    counter_t fb_count;
    counter_t fb_count_next;

    assign lookup_index = history ^ pc[`GHR_SIZE-1:0];
    assign taken        = counter_taken(lookup_count);

    // feedback uses the history as it was before this resolve shifts in.
    assign fb_index      = history ^ bo_pc[`GHR_SIZE-1:0];
    assign fb_count_next = counter_update(fb_count, bo_taken);

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            history <= '0;
        end else if (bo_valid) begin
            history <= {history[`GHR_SIZE-2:0], bo_taken}; // newest outcome at bit 0.
        end
    end

    pred_table #(
        .entry_t     (counter_t),
        .DEPTH_LOG2  (`GHR_SIZE),
        .RESET_VALUE (COUNTER_RESET)
    ) u_pht (
        .clk       (clk),
        .n_rst     (n_rst),
        .rd_index  (lookup_index),
        .rd_data   (lookup_count),
        .wr_en     (bo_valid),
        .wr_index  (fb_index),
        .wr_data   (fb_count_next),
        .rd2_index (fb_index),
        .rd2_data  (fb_count)
    );

endmodule

//--- branch_predictor.sv
// fetch-stage branch predictor.
// overrides the next pc when the target buffer knows the branch and gshare says taken.
module branch_predictor
    import cpu_pkg::*;
(
    input  logic clk,
    input  logic n_rst,

    // fetch lookup.
    input  pc_t  pc,

    // decode report.
    input  logic bv_valid,
    input  logic bv_branch,
    input  pc_t  bv_pc,

    // resolve report.
    input  logic bo_valid,
    input  logic bo_taken,
    input  pc_t  bo_pc,
    input  pc_t  bo_target,

    output logic pc_override,
    output pc_t  target
);

    logic hit;
    logic taken;
    pc_t  btb_target;

    branch_target_buffer u_btb (
        .clk       (clk),
        .n_rst     (n_rst),
        .pc        (pc),
        .bv_valid  (bv_valid),
        .bv_branch (bv_branch),
        .bv_pc     (bv_pc),
        .bo_valid  (bo_valid),
        .bo_taken  (bo_taken),
        .bo_pc     (bo_pc),
        .bo_target (bo_target),
        .hit       (hit),
        .target    (btb_target)
    );

    // direction only learns from resolves.
    branch_predictor_gshare u_gshare (
        .clk      (clk),
        .n_rst    (n_rst),
        .pc       (pc),
        .bo_valid (bo_valid),
        .bo_taken (bo_taken),
        .bo_pc    (bo_pc),
        .taken    (taken)
    );

    assign pc_override = hit && taken;
    assign target      = btb_target; // meaningful only with pc_override.

endmodule

//--- branch_predictor_asserts.sv
// port-level checks on the predictor, bound into every branch_predictor.
module branch_predictor_asserts
    import cpu_pkg::*;
(
    input logic clk,
    input logic n_rst,
    input pc_t  pc,
    input logic bv_valid,
    input logic bv_branch,
    input pc_t  bv_pc,
    input logic bo_valid,
    input logic bo_taken,
    input pc_t  bo_pc,
    input logic hit,
    input logic pc_override
);

    logic fill_no_clear;

    assign fill_no_clear = bo_valid && bo_taken && !(bv_valid && !bv_branch && bv_pc == bo_pc);

    // the buffer is empty from the first reset edge on.
    reset_quiet: assert property (@(posedge clk) !n_rst |=> !pc_override)
        else $error("pc_override set during reset or in the cycle after it");

    override_known: assert property (@(posedge clk) n_rst |-> !$isunknown(pc_override))
        else $error("pc_override is unknown out of reset");

    // a taken resolve must be found by a lookup of the same pc one cycle later.
    fill_hits: assert property (@(posedge clk) disable iff (!n_rst)
        fill_no_clear |=> (pc != $past(bo_pc)) || hit)
        else $error("no buffer hit after a taken resolve for this pc");

endmodule

bind branch_predictor branch_predictor_asserts u_asserts (.*);

//--- tb_branch_predictor.sv
`include "nand_cpu_defs.svh"

module tb_branch_predictor
    import cpu_pkg::*;
();

    localparam int RANDOM_CYCLES  = 2000;
    localparam int TIMEOUT_CYCLES = RANDOM_CYCLES + 1000; // directed part is ~110 cycles.
    localparam int BTB_ENTRIES    = 2 ** `BTB_INDEX_SIZE;
    localparam int PHT_ENTRIES    = 2 ** `GHR_SIZE;

    logic clk;
    logic n_rst;
    pc_t  pc;
    logic bv_valid;
    logic bv_branch;
    pc_t  bv_pc;
    logic bo_valid;
    logic bo_taken;
    pc_t  bo_pc;
    pc_t  bo_target;
    logic pc_override;
    pc_t  target;

    int          errors;
    int          checks;
    int          cycles;
    logic [31:0] seed;

    // model buffer entry is {valid, tag, target}.
    logic [`PC_SIZE+`BTB_TAG_SIZE:0] m_btb   [BTB_ENTRIES];
    logic [1:0]                      m_count [PHT_ENTRIES];
    logic [`GHR_SIZE-1:0]            m_hist;

    branch_predictor u_branch_predictor (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic expected_override(input pc_t addr);
        logic [`PC_SIZE+`BTB_TAG_SIZE:0] entry;
        entry = m_btb[addr[`BTB_INDEX_SIZE-1:0]];
        return entry[`PC_SIZE+`BTB_TAG_SIZE]
               && entry[`PC_SIZE+`BTB_TAG_SIZE-1:`PC_SIZE] == addr[`PC_SIZE-1:`BTB_INDEX_SIZE]
               && m_count[m_hist ^ addr[`GHR_SIZE-1:0]] >= 2'd2;
    endfunction

    function automatic pc_t expected_target(input pc_t addr);
        return m_btb[addr[`BTB_INDEX_SIZE-1:0]][`PC_SIZE-1:0];
    endfunction

    // applies this edge's reports after the cycle's predictions were compared.
    task automatic update_model();
        logic [`BTB_INDEX_SIZE-1:0] dec_idx;
        logic [`GHR_SIZE-1:0]       cidx;
        dec_idx = bv_pc[`BTB_INDEX_SIZE-1:0];
        cidx    = m_hist ^ bo_pc[`GHR_SIZE-1:0];
        if (!n_rst) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                m_btb[i] = '0;
            end
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                m_count[i] = 2'd1;
            end
            m_hist = '0;
        end else begin
            if (bo_valid && bo_taken) begin
                m_btb[bo_pc[`BTB_INDEX_SIZE-1:0]] =
                    {1'b1, bo_pc[`PC_SIZE-1:`BTB_INDEX_SIZE], bo_target};
            end else if (bv_valid && !bv_branch && m_btb[dec_idx][`PC_SIZE+`BTB_TAG_SIZE]
                         && m_btb[dec_idx][`PC_SIZE+`BTB_TAG_SIZE-1:`PC_SIZE]
                            == bv_pc[`PC_SIZE-1:`BTB_INDEX_SIZE]) begin
                m_btb[dec_idx] = '0;
            end
            if (bo_valid) begin
                if (bo_taken && m_count[cidx] != 2'd3) begin
                    m_count[cidx] = m_count[cidx] + 2'd1;
                end else if (!bo_taken && m_count[cidx] != 2'd0) begin
                    m_count[cidx] = m_count[cidx] - 2'd1;
                end
                m_hist = {m_hist[`GHR_SIZE-2:0], bo_taken};
            end
        end
    endtask

    always @(posedge clk) update_model();

    task automatic compare_value(input string name, input pc_t got, input pc_t expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    always begin
        @(negedge clk);
        #1; // one unit before the next rising edge.
        if (n_rst) begin
            compare_value("pc_override", pc_t'(pc_override), pc_t'(expected_override(pc)));
            if (expected_override(pc)) begin
                compare_value("target", target, expected_target(pc));
            end
        end
    end

    task automatic step(input pc_t p, input logic dv, input logic db, input pc_t dp,
                        input logic rv, input logic rt, input pc_t rp, input pc_t rtgt);
        @(posedge clk);
        pc        <= p;
        bv_valid  <= dv;
        bv_branch <= db;
        bv_pc     <= dp;
        bo_valid  <= rv;
        bo_taken  <= rt;
        bo_pc     <= rp;
        bo_target <= rtgt;
    endtask

    task automatic lookup(input pc_t p);
        step(p, 1'b0, 1'b0, '0, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic resolve(input pc_t p, input logic taken, input pc_t tgt);
        step(p, 1'b0, 1'b0, '0, 1'b1, taken, p, tgt);
    endtask

    task automatic decode(input pc_t p, input logic is_branch);
        step(p, 1'b1, is_branch, p, 1'b0, 1'b0, '0, '0);
    endtask

    // directed check with the value worked out by hand.
    task automatic expect_override(input pc_t p, input logic ovr, input pc_t tgt);
        lookup(p);
        #1;
        compare_value("pc_override", pc_t'(pc_override), pc_t'(ovr));
        if (ovr) begin
            compare_value("target", target, tgt);
        end
    endtask

    initial begin
        logic [31:0] rnd_pc;
        logic [31:0] rnd_ctl;
        seed      = 32'h3d9c;
        errors    = 0;
        checks    = 0;
        n_rst     = 1'b0;
        pc        = '0;
        bv_valid  = 1'b0;
        bv_branch = 1'b0;
        bv_pc     = '0;
        bo_valid  = 1'b0;
        bo_taken  = 1'b0;
        bo_pc     = '0;
        bo_target = '0;
        repeat (4) @(posedge clk);
        n_rst <= 1'b1;

        repeat (16) begin
            rnd_pc = next_random();
            expect_override(rnd_pc[31:16], 1'b0, '0);
        end

        // loop branch, history settles at all ones.
        resolve(16'h0120, 1'b1, 16'h0100);
        expect_override(16'h0120, 1'b0, '0);
        repeat (10) resolve(16'h0120, 1'b1, 16'h0100);
        expect_override(16'h0120, 1'b1, 16'h0100);

        // six taken resolves bring the history back to all ones.
        // so the lookup reads the same counter that the not-taken moved.
        repeat (8) resolve(16'h0120, 1'b1, 16'h0100);
        resolve(16'h0120, 1'b0, 16'h0100);
        repeat (6) resolve(16'h0120, 1'b1, 16'h0100);
        expect_override(16'h0120, 1'b1, 16'h0100);
        resolve(16'h0120, 1'b0, 16'h0100);
        repeat (6) resolve(16'h0120, 1'b1, 16'h0100);
        expect_override(16'h0120, 1'b0, '0);

        // same branch behind different outcome patterns of another one.
        for (int k = 0; k < 4; k++) begin
            repeat (3) begin
                resolve(16'h0ab9, k[0], 16'h0b00);
                resolve(16'h0ab9, k[1], 16'h0b00);
                resolve(16'h0347, 1'b1, 16'h0400);
                lookup(16'h0347);
            end
        end

        repeat (2) resolve(16'h1234, 1'b1, 16'h2000); // twice, so its counter reads taken.
        expect_override(16'h5234, 1'b0, '0);
        decode(16'h5234, 1'b0);
        step(16'h1234, 1'b1, 1'b0, 16'h1234, 1'b1, 1'b1, 16'h1234, 16'h2200);
        decode(16'h1234, 1'b0);
        expect_override(16'h1234, 1'b0, '0);

        // 32 pcs over 16 entries, so tags alias.
        repeat (RANDOM_CYCLES) begin
            rnd_pc  = next_random();
            rnd_ctl = next_random();
            step({11'h015, rnd_pc[20:16]}, rnd_ctl[16], rnd_ctl[17], {11'h015, rnd_pc[25:21]},
                 rnd_ctl[18], rnd_ctl[19] | rnd_ctl[20], {11'h015, rnd_pc[30:26]},
                 {rnd_ctl[31:21], 5'd0});
        end
        repeat (2) lookup(16'h0120);

        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("test timed out after %0d cycles, %0d errors so far", cycles, errors);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- src.f
+incdir+.
cpu_pkg.sv
bp_pkg.sv
pred_table.sv
branch_target_buffer.sv
branch_predictor_gshare.sv
branch_predictor.sv
branch_predictor_asserts.sv
tb_branch_predictor.sv

//--- run.sh
#!/bin/sh
# build the testbench with verilator and run it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_branch_predictor \
    -o sim_branch_predictor
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_branch_predictor)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1
